//--- nx_pkg.sv
// Shared sizes and widths of the logic grid
// Message fields, command codes, opcodes and APB register map
`default_nettype none

package nx_pkg;

    // --------------------------------------------------
    // Array sizes and widths
    // --------------------------------------------------
    localparam int NX_NODES      = 4;
    localparam int NX_NODE_W     = 2;
    localparam int NX_MSG_W      = 32;
    localparam int NX_REGS       = 8;
    localparam int NX_REG_IDX_W  = 3;
    localparam int NX_MAX_INSTRS = 16;
    // Holds 0 to 16 inclusive
    localparam int NX_COUNT_W    = 5;
    localparam int NX_INSTR_W    = 11;
    // Result word is run count above outputs
    localparam int NX_RUNS_W     = 8;
    localparam int NX_RESULT_W   = NX_RUNS_W + NX_REGS;

    // --------------------------------------------------
    // Message and instruction fields
    // --------------------------------------------------
    localparam int NX_CMD_HI  = 31;
    localparam int NX_CMD_LO  = 30;
    localparam int NX_NODE_HI = 29;
    localparam int NX_NODE_LO = 28;

    // Opcode, source a, source b, destination
    localparam int NX_OP_HI    = 10;
    localparam int NX_OP_LO    = 9;
    localparam int NX_SRC_A_LO = 6;
    localparam int NX_SRC_B_LO = 3;
    localparam int NX_DST_LO   = 0;

    // Command codes
    localparam logic [1:0] NX_CMD_LOAD    = 2'd0;
    localparam logic [1:0] NX_CMD_INPUTS  = 2'd1;
    localparam logic [1:0] NX_CMD_TRIGGER = 2'd2;
    localparam logic [1:0] NX_CMD_CLEAR   = 2'd3;

    // Opcodes
    localparam logic [1:0] NX_OP_AND  = 2'd0;
    localparam logic [1:0] NX_OP_OR   = 2'd1;
    localparam logic [1:0] NX_OP_XOR  = 2'd2;
    localparam logic [1:0] NX_OP_NAND = 2'd3;

    // --------------------------------------------------
    // APB register map
    // --------------------------------------------------
    localparam int NX_APB_AW = 8;
    localparam logic [NX_APB_AW-1:0] NX_REG_MSG         = 8'h00;
    localparam logic [NX_APB_AW-1:0] NX_REG_STATUS      = 8'h04;
    localparam logic [NX_APB_AW-1:0] NX_REG_RESULT_BASE = 8'h10;

endpackage : nx_pkg

`default_nettype wire

//--- nx_apb_host.sv
// APB slave of the logic grid
// Message register writes become stream beats, reads return status and results
`timescale 1ns/1ps
`default_nettype none

module nx_apb_host
    import nx_pkg::*;
(
      input  logic                                  clk_i
    , input  logic                                  reset_i
    // APB slave
    , input  logic                                  psel_i
    , input  logic                                  penable_i
    , input  logic                                  pwrite_i
    , input  logic [NX_APB_AW-1:0]                  paddr_i
    , input  logic [NX_MSG_W-1:0]                   pwdata_i
    , output logic [NX_MSG_W-1:0]                   prdata_o
    , output logic                                  pready_o
    , output logic                                  pslverr_o
    // Message stream to dispatcher
    , output logic [NX_MSG_W-1:0]                   msg_data_o
    , output logic                                  msg_valid_o
    , input  logic                                  msg_ready_i
    // Node status and collected results
    , input  logic [NX_NODES-1:0]                   busy_i
    , input  logic [NX_NODES-1:0][NX_RESULT_W-1:0]  results_i
);

logic                 setup, access;
logic                 is_msg, is_status, is_result;
logic                 msg_wr, legal;
logic [NX_APB_AW-1:0] res_off;
logic [NX_NODE_W-1:0] res_idx;
logic [NX_MSG_W-1:0]  rdata_d, prdata_q;

// --------------------------------------------------
// Address decode
// --------------------------------------------------

assign setup  = psel_i && !penable_i;
assign access = psel_i && penable_i;

assign is_msg    = (paddr_i == NX_REG_MSG);
assign is_status = (paddr_i == NX_REG_STATUS);

// Result words sit at base + 4*i, word aligned only
assign res_off   = paddr_i - NX_REG_RESULT_BASE;
assign res_idx   = res_off[NX_NODE_W+1:2];
assign is_result = (paddr_i >= NX_REG_RESULT_BASE)
                && (res_off < NX_APB_AW'(4 * NX_NODES))
                && (res_off[1:0] == 2'b00);

// Message register is write-only, the rest read-only
assign msg_wr = pwrite_i && is_msg;
assign legal  = pwrite_i ? is_msg : (is_status || is_result);

// --------------------------------------------------
// Write path
// --------------------------------------------------

// Beat offered for the whole access phase
assign msg_valid_o = access && msg_wr;
assign msg_data_o  = pwdata_i;

// Writes stall until the dispatcher has room
assign pready_o  = access && (!msg_wr || msg_ready_i);
assign pslverr_o = access && !legal;

// --------------------------------------------------
// Read path
// --------------------------------------------------

always_comb begin
    rdata_d = '0;
    if (is_status) begin
        rdata_d[NX_NODES-1:0] = busy_i;
    end else if (is_result) begin
        rdata_d[NX_RESULT_W-1:0] = results_i[res_idx];
    end
end

// Sampled at end of setup, valid throughout access
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        prdata_q <= '0;
    end else if (setup && !pwrite_i) begin
        prdata_q <= rdata_d;
    end
end

assign prdata_o = prdata_q;

endmodule : nx_apb_host

`default_nettype wire

//--- nx_msg_dispatch.sv
// Single-entry message holder
// Steers the held message to the node named in its node field
`timescale 1ns/1ps
`default_nettype none

module nx_msg_dispatch
    import nx_pkg::*;
(
      input  logic                               clk_i
    , input  logic                               reset_i
    // Inbound message stream from host
    , input  logic [NX_MSG_W-1:0]                msg_data_i
    , input  logic                               msg_valid_i
    , output logic                               msg_ready_o
    // One outbound stream per node
    , output logic [NX_NODES-1:0][NX_MSG_W-1:0]  node_data_o
    , output logic [NX_NODES-1:0]                node_valid_o
    , input  logic [NX_NODES-1:0]                node_ready_i
);

logic                 full_q;
logic [NX_MSG_W-1:0]  data_q;
logic [NX_NODE_W-1:0] target;
logic                 take, drain;

// --------------------------------------------------
// Routing
// --------------------------------------------------

assign target = data_q[NX_NODE_HI:NX_NODE_LO];

// Only the addressed lane sees valid
always_comb begin
    node_valid_o         = '0;
    node_valid_o[target] = full_q;
end

// Payload is shared across all lanes
always_comb begin
    for (int i = 0; i < NX_NODES; i++) begin
        node_data_o[i] = data_q;
    end
end

// --------------------------------------------------
// Slot control
// --------------------------------------------------

// Slot frees on the target's handshake
assign drain = |(node_valid_o & node_ready_i);

// Refill allowed on the same edge as a drain
assign msg_ready_o = !full_q || drain;
assign take        = msg_valid_i && msg_ready_o;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        full_q <= 1'b0;
    end else if (take) begin
        full_q <= 1'b1;
    end else if (drain) begin
        full_q <= 1'b0;
    end
end

always_ff @(posedge clk_i) begin
    if (take) begin
        data_q <= msg_data_i;
    end
end

endmodule : nx_msg_dispatch

`default_nettype wire

//--- nx_node.sv
// Logic evaluation node
// Instruction store, input latch, working registers and run sequencer
`timescale 1ns/1ps
`default_nettype none

module nx_node
    import nx_pkg::*;
(
      input  logic                clk_i
    , input  logic                reset_i
    // Inbound message stream
    , input  logic [NX_MSG_W-1:0] msg_data_i
    , input  logic                msg_valid_i
    , output logic                msg_ready_o
    // Run status and results
    , output logic                busy_o
    , output logic                done_o
    , output logic [NX_REGS-1:0]  outputs_o
);

logic [NX_INSTR_W-1:0]   store_q [NX_MAX_INSTRS];
logic [NX_COUNT_W-1:0]   count_q;
logic [NX_REGS-1:0]      inputs_q;
logic [NX_REGS-1:0]      regs_q;
logic [NX_REGS-1:0]      outputs_q;
logic [NX_COUNT_W-1:0]   pc_q;
logic                    busy_q, done_q;

logic                    accept, store_full, trigger, run_end;
logic [1:0]              cmd;
logic [NX_INSTR_W-1:0]   instr;
logic [1:0]              op;
logic [NX_REG_IDX_W-1:0] src_a, src_b, dst;
logic                    opnd_a, opnd_b, result;

// --------------------------------------------------
// Message intake
// --------------------------------------------------

// No messages taken mid-run
assign msg_ready_o = !busy_q;
assign accept      = msg_valid_i && msg_ready_o;
assign cmd         = msg_data_i[NX_CMD_HI:NX_CMD_LO];
assign trigger     = accept && (cmd == NX_CMD_TRIGGER);
assign store_full  = (count_q == NX_COUNT_W'(NX_MAX_INSTRS));

// Append at fill count, full store drops the load
always_ff @(posedge clk_i) begin
    if (accept && (cmd == NX_CMD_LOAD) && !store_full) begin
        store_q[count_q[$clog2(NX_MAX_INSTRS)-1:0]] <= msg_data_i[NX_INSTR_W-1:0];
    end
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        count_q  <= '0;
        inputs_q <= '0;
    end else if (accept) begin
        case (cmd)
            NX_CMD_LOAD: begin
                if (!store_full) begin
                    count_q <= count_q + 1'b1;
                end
            end
            NX_CMD_INPUTS: inputs_q <= msg_data_i[NX_REGS-1:0];
            NX_CMD_CLEAR:  count_q  <= '0;
            default: ;
        endcase
    end
end

// --------------------------------------------------
// Instruction decode and evaluate
// --------------------------------------------------

assign instr = store_q[pc_q[$clog2(NX_MAX_INSTRS)-1:0]];
assign op    = instr[NX_OP_HI:NX_OP_LO];
assign src_a = instr[NX_SRC_A_LO +: NX_REG_IDX_W];
assign src_b = instr[NX_SRC_B_LO +: NX_REG_IDX_W];
assign dst   = instr[NX_DST_LO  +: NX_REG_IDX_W];

assign opnd_a = regs_q[src_a];
assign opnd_b = regs_q[src_b];

always_comb begin
    case (op)
        NX_OP_AND:  result = opnd_a & opnd_b;
        NX_OP_OR:   result = opnd_a | opnd_b;
        NX_OP_XOR:  result = opnd_a ^ opnd_b;
        default:    result = !(opnd_a & opnd_b);
    endcase
end

// --------------------------------------------------
// Sequencer
// --------------------------------------------------

// Run ends once every stored instruction has executed
assign run_end = (pc_q == count_q);

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        busy_q    <= 1'b0;
        done_q    <= 1'b0;
        pc_q      <= '0;
        outputs_q <= '0;
    end else begin
        done_q <= 1'b0;
        if (trigger) begin
            busy_q <= 1'b1;
            pc_q   <= '0;
        end else if (busy_q) begin
            if (run_end) begin
                // Publish and drop busy together
                busy_q    <= 1'b0;
                done_q    <= 1'b1;
                outputs_q <= regs_q;
            end else begin
                pc_q <= pc_q + 1'b1;
            end
        end
    end
end

// Working registers seeded from the input latch
always_ff @(posedge clk_i) begin
    if (trigger) begin
        regs_q <= inputs_q;
    end else if (busy_q && !run_end) begin
        regs_q[dst] <= result;
    end
end

assign busy_o    = busy_q;
assign done_o    = done_q;
assign outputs_o = outputs_q;

endmodule : nx_node

`default_nettype wire

//--- nx_result_collect.sv
// Result collector
// Latches node outputs on completion, counts completed runs per node
`timescale 1ns/1ps
`default_nettype none

module nx_result_collect
    import nx_pkg::*;
(
      input  logic                                  clk_i
    , input  logic                                  reset_i
    // Node completions
    , input  logic [NX_NODES-1:0][NX_REGS-1:0]      outputs_i
    , input  logic [NX_NODES-1:0]                   done_i
    // Packed words for the host
    , output logic [NX_NODES-1:0][NX_RESULT_W-1:0]  results_o
);

logic [NX_NODES-1:0][NX_REGS-1:0]   out_q;
logic [NX_NODES-1:0][NX_RUNS_W-1:0] runs_q;

// --------------------------------------------------
// Capture
// --------------------------------------------------

// Run counter wraps at 8 bits
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        out_q  <= '0;
        runs_q <= '0;
    end else begin
        for (int i = 0; i < NX_NODES; i++) begin
            if (done_i[i]) begin
                out_q[i]  <= outputs_i[i];
                runs_q[i] <= runs_q[i] + 1'b1;
            end
        end
    end
end

// --------------------------------------------------
// Packing
// --------------------------------------------------

// Count in the upper byte, outputs below
always_comb begin
    for (int i = 0; i < NX_NODES; i++) begin
        results_o[i] = {runs_q[i], out_q[i]};
    end
end

endmodule : nx_result_collect

`default_nettype wire

//--- nx_grid_top.sv
// Top level of the logic grid
// APB host, dispatcher, row of nodes and result collector
`timescale 1ns/1ps
`default_nettype none

module nx_grid_top
    import nx_pkg::*;
(
      input  logic                 clk_i
    , input  logic                 reset_i
    // APB slave
    , input  logic                 psel_i
    , input  logic                 penable_i
    , input  logic                 pwrite_i
    , input  logic [NX_APB_AW-1:0] paddr_i
    , input  logic [NX_MSG_W-1:0]  pwdata_i
    , output logic [NX_MSG_W-1:0]  prdata_o
    , output logic                 pready_o
    , output logic                 pslverr_o
);

// Host to dispatcher
logic [NX_MSG_W-1:0] msg_data;
logic                msg_valid, msg_ready;

// Dispatcher to nodes, nodes to collector
logic [NX_NODES-1:0][NX_MSG_W-1:0]    node_data;
logic [NX_NODES-1:0]                  node_valid, node_ready;
logic [NX_NODES-1:0]                  node_busy, node_done;
logic [NX_NODES-1:0][NX_REGS-1:0]     node_outputs;
logic [NX_NODES-1:0][NX_RESULT_W-1:0] results;

// --------------------------------------------------
// Host and dispatch
// --------------------------------------------------

nx_apb_host u_host (
      .clk_i      (clk_i    )
    , .reset_i    (reset_i  )
    , .psel_i     (psel_i   )
    , .penable_i  (penable_i)
    , .pwrite_i   (pwrite_i )
    , .paddr_i    (paddr_i  )
    , .pwdata_i   (pwdata_i )
    , .prdata_o   (prdata_o )
    , .pready_o   (pready_o )
    , .pslverr_o  (pslverr_o)
    , .msg_data_o (msg_data )
    , .msg_valid_o(msg_valid)
    , .msg_ready_i(msg_ready)
    , .busy_i     (node_busy)
    , .results_i  (results  )
);

nx_msg_dispatch u_dispatch (
      .clk_i       (clk_i     )
    , .reset_i     (reset_i   )
    , .msg_data_i  (msg_data  )
    , .msg_valid_i (msg_valid )
    , .msg_ready_o (msg_ready )
    , .node_data_o (node_data )
    , .node_valid_o(node_valid)
    , .node_ready_i(node_ready)
);

// --------------------------------------------------
// Node row
// --------------------------------------------------

for (genvar i = 0; i < NX_NODES; i++) begin : g_node
    nx_node u_node (
          .clk_i      (clk_i          )
        , .reset_i    (reset_i        )
        , .msg_data_i (node_data[i]   )
        , .msg_valid_i(node_valid[i]  )
        , .msg_ready_o(node_ready[i]  )
        , .busy_o     (node_busy[i]   )
        , .done_o     (node_done[i]   )
        , .outputs_o  (node_outputs[i])
    );
end

nx_result_collect u_collect (
      .clk_i    (clk_i       )
    , .reset_i  (reset_i     )
    , .outputs_i(node_outputs)
    , .done_i   (node_done   )
    , .results_o(results     )
);

endmodule : nx_grid_top

`default_nettype wire

//--- tb_nx_grid.sv
// Testbench for the logic grid
// APB driver tasks, per-node model, random programs and checks
`timescale 1ns/1ps
`default_nettype none

module tb_nx_grid
    import nx_pkg::*;
();

localparam int APB_TIMEOUT  = 200;
localparam int POLL_TIMEOUT = 100;

logic                 clk_i;
logic                 reset_i;
logic                 psel_i;
logic                 penable_i;
logic                 pwrite_i;
logic [NX_APB_AW-1:0] paddr_i;
logic [NX_MSG_W-1:0]  pwdata_i;
logic [NX_MSG_W-1:0]  prdata_o;
logic                 pready_o;
logic                 pslverr_o;

// Model state per node
logic [NX_INSTR_W-1:0] m_store [NX_NODES][NX_MAX_INSTRS];
int                    m_count [NX_NODES];
logic [NX_REGS-1:0]    m_inputs [NX_NODES];
// Expected result of the latest trigger
logic [NX_REGS-1:0]    exp_out [NX_NODES];
logic [NX_RUNS_W-1:0]  exp_runs [NX_NODES];

integer seed;
string  test_name;
int     test_errors;
int     total_errors;
int     tests_run;
int     tests_bad;

nx_grid_top u_nx_grid_top (
      .clk_i    (clk_i    )
    , .reset_i  (reset_i  )
    , .psel_i   (psel_i   )
    , .penable_i(penable_i)
    , .pwrite_i (pwrite_i )
    , .paddr_i  (paddr_i  )
    , .pwdata_i (pwdata_i )
    , .prdata_o (prdata_o )
    , .pready_o (pready_o )
    , .pslverr_o(pslverr_o)
);

initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
end

// --------------------------------------------------
// Reporting
// --------------------------------------------------

task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
        $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, exp, act);
        test_errors++;
        total_errors++;
    end
endtask

task automatic abort_run(input string why);
    $display("ERROR in %s: %s", test_name, why);
    $display("Test failed");
    $finish;
endtask

task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
endtask

task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
        $display("test %s: ok", test_name);
    end else begin
        tests_bad++;
        $display("test %s: %0d mismatches", test_name, test_errors);
    end
endtask

// --------------------------------------------------
// APB driver
// --------------------------------------------------

// Setup cycle, then access until pready, sampled on the falling edge
task automatic apb_xfer(input logic wr, input logic [NX_APB_AW-1:0] addr,
                        input logic [NX_MSG_W-1:0] wdata,
                        output logic [NX_MSG_W-1:0] rdata, output logic err);
    int waited;
    bit done;
    waited = 0;
    done   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    while (!done && waited < APB_TIMEOUT) begin
        @(negedge clk_i);
        if (pready_o) begin
            rdata = prdata_o;
            err   = pslverr_o;
            done  = 1'b1;
        end
        // Transfer completes on this edge when pready was high
        @(posedge clk_i);
        waited++;
    end
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    if (!done) begin
        abort_run($sformatf("APB transfer to address %0h never completed", addr));
    end
endtask

task automatic apb_write(input logic [NX_APB_AW-1:0] addr, input logic [NX_MSG_W-1:0] data,
                         output logic err);
    logic [NX_MSG_W-1:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
endtask

task automatic apb_read(input logic [NX_APB_AW-1:0] addr, output logic [NX_MSG_W-1:0] data,
                        output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
endtask

function automatic logic [NX_APB_AW-1:0] result_addr(input int node);
    return NX_REG_RESULT_BASE + NX_APB_AW'(4 * node);
endfunction

// --------------------------------------------------
// Node model
// --------------------------------------------------

// Register file seeded from inputs, one instruction at a time
function automatic logic [NX_REGS-1:0] eval_node(input int node);
    logic [NX_REGS-1:0]    regs;
    logic [NX_INSTR_W-1:0] ins;
    logic                  a;
    logic                  b;
    logic                  r;
    regs = m_inputs[node];
    for (int k = 0; k < m_count[node]; k++) begin
        ins = m_store[node][k];
        a   = regs[ins[8:6]];
        b   = regs[ins[5:3]];
        case (ins[10:9])
            NX_OP_AND: r = a & b;
            NX_OP_OR:  r = a | b;
            NX_OP_XOR: r = a ^ b;
            default:   r = ~(a & b);
        endcase
        regs[ins[2:0]] = r;
    end
    return regs;
endfunction

// Model follows message order per node, same as the single dispatcher slot
task automatic send_msg(input logic [1:0] cmd, input int node,
                        input logic [NX_INSTR_W-1:0] payload);
    logic                err;
    logic [NX_MSG_W-1:0] word;
    word                        = '0;
    word[NX_CMD_HI:NX_CMD_LO]   = cmd;
    word[NX_NODE_HI:NX_NODE_LO] = node[NX_NODE_W-1:0];
    word[NX_INSTR_W-1:0]        = payload;
    apb_write(NX_REG_MSG, word, err);
    check("message write pslverr", 0, err);
    case (cmd)
        NX_CMD_LOAD: begin
            // Full store drops the load
            if (m_count[node] < NX_MAX_INSTRS) begin
                m_store[node][m_count[node]] = payload;
                m_count[node]++;
            end
        end
        NX_CMD_INPUTS: m_inputs[node] = payload[NX_REGS-1:0];
        NX_CMD_CLEAR:  m_count[node]  = 0;
        NX_CMD_TRIGGER: begin
            exp_out[node]  = eval_node(node);
            exp_runs[node] = exp_runs[node] + 1'b1;
        end
        default: ;
    endcase
endtask

task automatic load_random_program(input int node, input int len);
    send_msg(NX_CMD_CLEAR, node, '0);
    for (int k = 0; k < len; k++) begin
        send_msg(NX_CMD_LOAD, node, NX_INSTR_W'($random(seed)));
    end
    send_msg(NX_CMD_INPUTS, node, NX_INSTR_W'(NX_REGS'($random(seed))));
endtask

// Poll the result word until the run count reaches the expected value
task automatic wait_run(input int node, output logic [NX_MSG_W-1:0] word);
    logic err;
    int   polls;
    polls = 0;
    do begin
        apb_read(result_addr(node), word, err);
        polls++;
    end while (word[15:8] != exp_runs[node] && polls < POLL_TIMEOUT);
    if (word[15:8] != exp_runs[node]) begin
        abort_run($sformatf("node %0d run count stuck at %0d", node, word[15:8]));
    end else begin
        check($sformatf("node %0d outputs", node), exp_out[node], word[7:0]);
    end
endtask

// --------------------------------------------------
// Test sequence
// --------------------------------------------------

initial begin
    logic [NX_MSG_W-1:0] word;
    logic                err;
    logic [NX_REGS-1:0]  in_val;
    seed         = 32'h81df_9fd0;
    total_errors = 0;
    tests_run    = 0;
    tests_bad    = 0;
    test_name    = "reset";
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= '0;
    pwdata_i  <= '0;
    reset_i   <= 1'b1;
    for (int n = 0; n < NX_NODES; n++) begin
        m_count[n]  = 0;
        m_inputs[n] = '0;
        exp_out[n]  = '0;
        exp_runs[n] = '0;
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    start_test("reset_state");
    apb_read(NX_REG_STATUS, word, err);
    check("status", 0, word);
    check("status read pslverr", 0, err);
    for (int n = 0; n < NX_NODES; n++) begin
        apb_read(result_addr(n), word, err);
        check($sformatf("result word %0d", n), 0, word);
        check($sformatf("result %0d read pslverr", n), 0, err);
    end
    end_test();

    // Empty store passes inputs straight through
    start_test("empty_store");
    for (int n = 0; n < NX_NODES; n++) begin
        in_val = NX_REGS'($random(seed));
        send_msg(NX_CMD_INPUTS, n, NX_INSTR_W'(in_val));
        send_msg(NX_CMD_TRIGGER, n, '0);
        wait_run(n, word);
        check($sformatf("node %0d run word", n), {16'h0, 8'd1, in_val}, word);
    end
    end_test();

    start_test("random_programs");
    for (int round = 0; round < 3; round++) begin
        for (int n = 0; n < NX_NODES; n++) begin
            load_random_program(n, 1 + ($unsigned($random(seed)) % NX_MAX_INSTRS));
            send_msg(NX_CMD_TRIGGER, n, '0);
            wait_run(n, word);
        end
    end
    end_test();

    // Old program replaced, 17th load dropped
    start_test("clear_and_overflow");
    load_random_program(2, 6);
    load_random_program(2, NX_MAX_INSTRS);
    send_msg(NX_CMD_LOAD, 2, NX_INSTR_W'($random(seed)));
    send_msg(NX_CMD_TRIGGER, 2, '0);
    wait_run(2, word);
    end_test();

    // Each inputs message queues behind a running node and stalls the next write
    start_test("back_to_back");
    for (int n = 0; n < NX_NODES; n++) begin
        load_random_program(n, NX_MAX_INSTRS);
    end
    for (int n = 0; n < NX_NODES; n++) begin
        send_msg(NX_CMD_TRIGGER, n, '0);
        send_msg(NX_CMD_INPUTS, n, NX_INSTR_W'(NX_REGS'($random(seed))));
    end
    for (int n = 0; n < NX_NODES; n++) begin
        wait_run(n, word);
    end
    // Exactly one completion each
    for (int n = 0; n < NX_NODES; n++) begin
        apb_read(result_addr(n), word, err);
        check($sformatf("node %0d run word", n), {16'h0, exp_runs[n], exp_out[n]}, word);
    end
    // Queued inputs arrived
    for (int n = 0; n < NX_NODES; n++) begin
        send_msg(NX_CMD_TRIGGER, n, '0);
    end
    // 17-cycle runs overlap the four trigger writes
    apb_read(NX_REG_STATUS, word, err);
    check("status while running", 32'hf, word);
    for (int n = 0; n < NX_NODES; n++) begin
        wait_run(n, word);
    end
    end_test();

    start_test("illegal_access");
    apb_read(8'h08, word, err);
    check("unmapped read pslverr", 1, err);
    apb_write(NX_REG_STATUS, {NX_CMD_TRIGGER, 30'h0}, err);
    check("status write pslverr", 1, err);
    apb_write(result_addr(1), {NX_CMD_TRIGGER, 2'd1, 28'h0}, err);
    check("result write pslverr", 1, err);
    apb_read(NX_REG_MSG, word, err);
    check("message read pslverr", 1, err);
    apb_read(8'h12, word, err);
    check("misaligned read pslverr", 1, err);
    repeat (30) @(posedge clk_i);
    apb_read(NX_REG_STATUS, word, err);
    check("status after errors", 0, word);
    for (int n = 0; n < NX_NODES; n++) begin
        apb_read(result_addr(n), word, err);
        check($sformatf("node %0d unchanged", n), {16'h0, exp_runs[n], exp_out[n]}, word);
    end
    end_test();

    $display("Summary: %0d tests, %0d with mismatches, %0d mismatches total",
             tests_run, tests_bad, total_errors);
    if (total_errors == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule : tb_nx_grid

`default_nettype wire

//--- vlog.f
nx_pkg.sv
nx_apb_host.sv
nx_msg_dispatch.sv
nx_node.sv
nx_result_collect.sv
nx_grid_top.sv
tb_nx_grid.sv
